// File: sources.f
src/seq_pkg.sv
src/instr_decode.sv
src/branch_cond.sv
src/seq_fsm.sv
src/control_gen.sv
src/sequence_control.sv
tb/tb_sequence_control.sv

// File: Bender.yml
package:
  name: sequence_control

sources:
  - files:
      - src/seq_pkg.sv
      - src/instr_decode.sv
      - src/branch_cond.sv
      - src/seq_fsm.sv
      - src/control_gen.sv
      - src/sequence_control.sv
  - target: test
    files:
      - tb/tb_sequence_control.sv

// File: tb/tb_sequence_control.sv
`timescale 1ns/10ps

module tb_sequence_control;
    import seq_pkg::*;

    typedef struct packed {
        logic [DATA_W-1:0] ir;
        logic              rnd;      // Random flags at apply time
        ctrl_t             exp_dec;  // DECODE cycle
        ctrl_t             exp_4th;  // EXECUTE or ALU_WB cycle
        logic [2:0]        cycles;   // ir_ld to next ir_ld
        logic              stop;     // HLT row
    } row_t;

    logic              Clk;
    logic              rst_n;
    logic [DATA_W-1:0] ir;
    alu_flags_t        flags;
    ctrl_t             ctrl;
    reg_fields_t       regs;
    logic              ready;
    logic              halt;

    row_t rows[$];
    int   errs   = 0;
    int   checks = 0;
    int   cyc    = 0;

    sequence_control dut0 (
        .Clk   (Clk),
        .rst_n (rst_n),
        .ir    (ir),
        .flags (flags),
        .ctrl  (ctrl),
        .regs  (regs),
        .ready (ready),
        .halt  (halt)
    );

    initial begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;  // 8 ns period
    end

    // Run limit grows with the table
    always @(posedge Clk) begin
        cyc <= cyc + 1;
        if (cyc > 5 * rows.size() + 40) begin
            $display("timeout after %0d cycles, DUT stopped producing ir_ld", cyc);
            $display(">>> FAIL");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    function automatic ctrl_t idle_word();
        ctrl_t c;
        c         = '0;
        c.alu_op  = ALU_NONE;
        c.out_sel = OUT_REGFILE;
        c.bra_src = BRA_DIRECT;
        return c;
    endfunction

    function automatic logic branch_taken(input opcode_e op, input alu_flags_t f);
        case (op)
            OP_BDQ, OP_BXQ: return f.z;
            OP_BDE, OP_BXE: return !f.z;
            OP_BDT, OP_BXT: return f.n != f.v;  // Signed less
            OP_BDS, OP_BXS: return f.c;
            default:        return 1'b0;
        endcase
    endfunction

    task automatic check_ctrl(input string tag, input ctrl_t exp);
        checks++;
        assert (ctrl === exp) else begin
            errs++;
            $display("mismatch ctrl in %s: got %h expected %h", tag, ctrl, exp);
        end
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errs++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic add_row(input opcode_e op, input logic ign, input ctrl_t d,
                           input ctrl_t x, input int n);
        row_t r;
        r.ir      = {op, ign, 10'($urandom)};  // Random register fields
        r.rnd     = (op >= OP_BDQ) && (op <= OP_BXS);
        r.exp_dec = d;
        r.exp_4th = x;
        r.cycles  = 3'(n);
        r.stop    = (op == OP_HLT);
        rows.push_back(r);
    endtask

    // Holds reset and walks READY and the first fetch up to the ir_ld cycle
    task automatic do_reset();
        ctrl_t w;
        w        = idle_word();
        w.pc_rst = 1'b1;
        rst_n    = 1'b0;
        repeat (10) begin
            @(negedge Clk);
            check_ctrl("reset", w);
            check_val("ready", ready, 0);
            check_val("halt", halt, 0);
        end
        rst_n = 1'b1;
        #2;
        check_ctrl("reset release", w);  // Still RESET until the next edge
        check_val("ready", ready, 0);
        @(negedge Clk);
        check_ctrl("ready state", idle_word());
        check_val("ready", ready, 1);
        @(negedge Clk);
        w        = idle_word();
        w.mem_en = 1'b1;
        check_ctrl("fetch address", w);
        @(negedge Clk);
        w        = idle_word();
        w.ir_ld  = 1'b1;
        w.pc_inc = 1'b1;
        check_ctrl("first ir_ld", w);
    endtask

    // ------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------
    task automatic fill_table();
        ctrl_t c;
        ctrl_t x;
        ctrl_t i0;
        i0 = idle_word();
        add_row(OP_NOP, 1'b0, i0, i0, 3);
        c        = idle_word();
        c.pc_ld  = 1'b1;
        c.pc_src = PC_SRC1;
        add_row(OP_JMP, 1'b0, c, i0, 3);
        c.stk_ld = 1'b1;  // JPL saves the return address
        add_row(OP_JPL, 1'b0, c, i0, 3);
        c        = idle_word();
        c.pc_ld  = 1'b1;
        c.pc_src = PC_RETURN;
        add_row(OP_RET, 1'b1, c, i0, 3);
        c        = idle_word();
        c.out_ld = 1'b1;
        add_row(OP_OTR, 1'b0, c, i0, 3);
        c        = idle_word();
        c.reg_we = 1'b1;
        add_row(OP_LDI, 1'b1, c, i0, 3);  // ZEXT is the resting select
        c          = idle_word();
        c.mem_en   = 1'b1;
        c.mem_wr   = 1'b1;
        c.addr_src = ADDR_IMM_HI;
        add_row(OP_ST, 1'b0, c, i0, 3);
        c.addr_src = ADDR_SRC2;
        add_row(OP_STX, 1'b1, c, i0, 3);
        c          = idle_word();
        c.reg_we   = 1'b1;
        c.data_src = DATA_SRC1;
        add_row(OP_MOV, 1'b0, c, i0, 3);

        // Branch results come from the random flags
        for (int k = 0; k < 8; k++) begin
            add_row(opcode_e'(OP_BDQ + k), k[0], i0, i0, 3);
        end

        // ALU ops with write-back
        for (int k = 0; k < 8; k++) begin
            c          = idle_word();
            c.alu_op   = alu_op_e'(k);
            c.flg_ld   = 1'b1;
            c.alu_ld   = 1'b1;
            x          = idle_word();
            x.reg_we   = 1'b1;
            x.data_src = DATA_ALU;
            add_row(opcode_e'(OP_ADD + k), 1'b0, c, x, 4);
        end
        c        = idle_word();
        c.alu_op = ALU_SUB;
        c.flg_ld = 1'b1;
        add_row(OP_SUB, 1'b1, c, i0, 3);  // Compare

        c          = idle_word();
        c.mem_en   = 1'b1;
        c.addr_src = ADDR_IMM_LO;
        x          = idle_word();
        x.reg_we   = 1'b1;
        x.data_src = DATA_MEM;
        add_row(OP_LD, 1'b0, c, x, 4);
        x          = idle_word();
        x.mem_en   = 1'b1;
        x.addr_src = ADDR_IMM_LO;
        x.out_ld   = 1'b1;
        x.out_sel  = OUT_MEM;
        add_row(OP_OTM, 1'b0, c, x, 4);

        add_row(OP_HLT, 1'b0, i0, i0, 3);
        add_row(OP_NOP, 1'b1, i0, i0, 3);          // After the second reset
        add_row(opcode_e'(5'd30), 1'b0, i0, i0, 3);  // Unused code acts as NOP
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        row_t       r;
        ctrl_t      exp;
        alu_flags_t fl;
        opcode_e    op;
        int         n;
        rst_n = 1'b0;
        ir    = '0;
        flags = '0;
        void'($urandom(68));
        fill_table();
        do_reset();

        foreach (rows[i]) begin
            r  = rows[i];
            op = opcode_e'(r.ir[OPC_MSB:OPC_LSB]);
            fl = r.rnd ? alu_flags_t'(4'($urandom)) : '0;
            ir    = r.ir;  // Falling edge of the ir_ld cycle
            flags = fl;
            exp   = r.exp_dec;
            if (r.rnd && branch_taken(op, fl)) begin
                exp.pc_ld   = 1'b1;
                exp.pc_src  = PC_BRANCH;
                exp.flg_rst = 1'b1;
                exp.bra_src = (op >= OP_BXQ) ? BRA_INDEXED : BRA_DIRECT;
            end

            @(negedge Clk);  // DECODE
            check_ctrl($sformatf("decode of row %0d", i), exp);
            check_val("regs", regs, {r.ir[11:9], r.ir[6:4], r.ir[2:0]});
            check_val("ready", ready, !r.stop);
            check_val("halt", halt, 0);

            if (r.stop) begin
                repeat (6) begin
                    @(negedge Clk);
                    check_val("halt", halt, 1);
                    check_val("ready", ready, 0);
                    check_val("ir_ld", ctrl.ir_ld, 0);
                end
                do_reset();
            end else begin
                n = 1;
                while (!ctrl.ir_ld) begin
                    @(negedge Clk);
                    n++;
                    if (n == 2 && r.cycles == 3'd4) begin
                        check_ctrl($sformatf("fourth cycle of row %0d", i), r.exp_4th);
                    end
                end
                check_val("cycles to next ir_ld", n, r.cycles);
            end
        end

        $display("errors: %0d, checks: %0d, rows: %0d", errs, checks, rows.size());
        if (errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: src/sequence_control.sv
`timescale 1ns/10ps

module sequence_control (
    input  logic                       Clk,
    input  logic                       rst_n,
    input  logic [seq_pkg::DATA_W-1:0] ir,     // Instruction register
    input  seq_pkg::alu_flags_t        flags,  // Latched ALU flags
    output seq_pkg::ctrl_t             ctrl,   // Datapath controls, active high
    output seq_pkg::reg_fields_t       regs,
    output logic                       ready,
    output logic                       halt
);
    import seq_pkg::*;

    decoded_t dec;
    state_e   state;
    logic     take_branch;

    // ------------------------------------------------------------
    // Decode and branch test
    // ------------------------------------------------------------
    instr_decode u_decode (
        .ir   (ir),
        .dec  (dec),
        .regs (regs)
    );

    branch_cond u_branch (
        .cond        (dec.cond),
        .flags       (flags),
        .take_branch (take_branch)
    );

    // ------------------------------------------------------------
    // Sequencer and controls
    // ------------------------------------------------------------
    seq_fsm u_fsm (
        .Clk   (Clk),
        .rst_n (rst_n),
        .dec   (dec),
        .state (state)
    );

    control_gen u_ctrl (
        .state       (state),
        .dec         (dec),
        .take_branch (take_branch),
        .ctrl        (ctrl),
        .ready       (ready),
        .halt        (halt)
    );

endmodule

// File: src/control_gen.sv
`timescale 1ns/10ps

module control_gen (
    input  seq_pkg::state_e   state,
    input  seq_pkg::decoded_t dec,
    input  logic              take_branch,
    output seq_pkg::ctrl_t    ctrl,
    output logic              ready,
    output logic              halt
);
    import seq_pkg::*;

    always_comb begin
        ctrl  = CTRL_IDLE;
        ready = 1'b1;
        halt  = 1'b0;

        case (state)
            S_RESET: begin
                ctrl.pc_rst = 1'b1;
                ready       = 1'b0;
            end

            S_HALT: begin
                halt  = 1'b1;
                ready = 1'b0;
            end

            // ------------------------------------------------------------
            // Fetch
            // ------------------------------------------------------------
            S_FETCH_ADDR: ctrl.mem_en = 1'b1;  // Read at PC

            S_FETCH_IR: begin
                ctrl.ir_ld  = 1'b1;
                ctrl.pc_inc = 1'b1;  // Bump PC on the same edge
            end

            // ------------------------------------------------------------
            // Decode
            // ------------------------------------------------------------
            S_DECODE: begin
                case (dec.opcode)
                    OP_HLT: ready = 1'b0;

                    // Flow
                    OP_JMP, OP_JPL: begin
                        ctrl.pc_ld  = 1'b1;
                        ctrl.pc_src = PC_SRC1;            // Absolute target in src1
                        ctrl.stk_ld = (dec.opcode == OP_JPL);  // Save return address
                    end
                    OP_RET: begin
                        ctrl.pc_ld  = 1'b1;
                        ctrl.pc_src = PC_RETURN;
                    end

                    OP_OTR: begin
                        ctrl.out_ld  = 1'b1;
                        ctrl.out_sel = OUT_REGFILE;
                    end

                    // Address phase, data follows in EXECUTE
                    OP_OTM, OP_LD: begin
                        ctrl.mem_en   = 1'b1;
                        ctrl.addr_src = ADDR_IMM_LO;
                    end

                    OP_LDI: begin
                        ctrl.reg_we   = 1'b1;
                        ctrl.data_src = DATA_ZEXT;  // Zero extended low byte
                    end

                    // Stores
                    OP_ST, OP_STX: begin
                        ctrl.mem_en   = 1'b1;
                        ctrl.mem_wr   = 1'b1;
                        ctrl.addr_src = (dec.opcode == OP_ST) ? ADDR_IMM_HI : ADDR_SRC2;
                    end

                    OP_MOV: begin
                        ctrl.reg_we   = 1'b1;
                        ctrl.data_src = DATA_SRC1;
                    end

                    default: ;  // NOP, branches and ALU handled below
                endcase

                // Flags are kept for every ALU op
                if (dec.alu_op != ALU_NONE) begin
                    ctrl.alu_op = dec.alu_op;
                    ctrl.flg_ld = 1'b1;
                    ctrl.alu_ld = (dec.seq_kind == SEQ_ALU_WB);  // Result held for WB
                end

                // Non-branch opcodes carry COND_NEVER
                if (take_branch) begin
                    ctrl.pc_ld   = 1'b1;
                    ctrl.pc_src  = PC_BRANCH;
                    ctrl.bra_src = dec.bra_src;
                    ctrl.flg_rst = 1'b1;
                end
            end

            // ------------------------------------------------------------
            // Fourth cycle
            // ------------------------------------------------------------
            S_EXECUTE: begin
                if (dec.opcode == OP_LD) begin
                    ctrl.reg_we   = 1'b1;
                    ctrl.data_src = DATA_MEM;
                end else if (dec.opcode == OP_OTM) begin
                    ctrl.mem_en   = 1'b1;         // Keep the word on the bus
                    ctrl.addr_src = ADDR_IMM_LO;
                    ctrl.out_ld   = 1'b1;
                    ctrl.out_sel  = OUT_MEM;
                end
            end

            S_ALU_WB: begin
                ctrl.reg_we   = 1'b1;
                ctrl.data_src = DATA_ALU;
            end

            default: ;  // READY drives nothing
        endcase
    end

endmodule

// File: src/seq_fsm.sv
`timescale 1ns/10ps

module seq_fsm (
    input  logic              Clk,
    input  logic              rst_n,
    input  seq_pkg::decoded_t dec,
    output seq_pkg::state_e   state
);
    import seq_pkg::*;

    state_e next_state;

    // ------------------------------------------------------------
    // State register
    // ------------------------------------------------------------
    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_RESET;
        end else begin
            state <= next_state;
        end
    end

    // ------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------
    always_comb begin
        case (state)
            S_RESET:      next_state = S_READY;
            S_READY:      next_state = S_FETCH_ADDR;

            // PC onto the memory address
            S_FETCH_ADDR: next_state = S_FETCH_IR;

            // Memory word into IR
            S_FETCH_IR:   next_state = S_DECODE;

            // Tail length comes from the decoder
            S_DECODE: begin
                case (dec.seq_kind)
                    SEQ_MEM_EXEC: next_state = S_EXECUTE;
                    SEQ_ALU_WB:   next_state = S_ALU_WB;
                    SEQ_STOP:     next_state = S_HALT;
                    default:      next_state = S_FETCH_ADDR;
                endcase
            end

            // Fourth cycles always go back to fetch
            S_EXECUTE:    next_state = S_FETCH_ADDR;
            S_ALU_WB:     next_state = S_FETCH_ADDR;

            S_HALT:       next_state = S_HALT;  // Left only by rst_n

            // Illegal encodings restart the sequence
            default:      next_state = S_RESET;
        endcase
    end

endmodule

// File: src/branch_cond.sv
`timescale 1ns/10ps

module branch_cond (
    input  seq_pkg::cond_e      cond,
    input  seq_pkg::alu_flags_t flags,
    output logic                take_branch
);
    import seq_pkg::*;

    // One rule per flag test, ordered as the cond codes after NEVER
    logic [FLAG_W-1:0] rule_hit;

    assign rule_hit[0] = flags.z;             // Equal
    assign rule_hit[1] = ~flags.z;            // Not equal
    assign rule_hit[2] = flags.n ^ flags.v;   // Signed less than
    assign rule_hit[3] = flags.c;             // Carry set

    always_comb begin
        case (cond)
            COND_ZERO:     take_branch = rule_hit[0];
            COND_NOT_ZERO: take_branch = rule_hit[1];
            COND_LESS:     take_branch = rule_hit[2];
            COND_CARRY:    take_branch = rule_hit[3];
            default:       take_branch = 1'b0;  // NEVER and unused codes
        endcase
    end

endmodule

// File: src/instr_decode.sv
`timescale 1ns/10ps

module instr_decode (
    input  logic [seq_pkg::DATA_W-1:0] ir,    // Instruction register contents
    output seq_pkg::decoded_t          dec,
    output seq_pkg::reg_fields_t       regs
);
    import seq_pkg::*;

    logic ignore_dest;

    // ------------------------------------------------------------
    // Register fields go straight out
    // ------------------------------------------------------------
    assign regs.dest = ir[DEST_MSB:DEST_LSB];
    assign regs.src2 = ir[SRC2_MSB:SRC2_LSB];
    assign regs.src1 = ir[SRC1_MSB:SRC1_LSB];

    assign ignore_dest = ir[IGN_DEST_BIT];

    // ------------------------------------------------------------
    // Opcode classification
    // ------------------------------------------------------------
    always_comb begin
        dec.opcode   = opcode_e'(ir[OPC_MSB:OPC_LSB]);
        dec.alu_op   = ALU_NONE;
        dec.cond     = COND_NEVER;  // Only branches test flags
        dec.bra_src  = BRA_DIRECT;
        dec.seq_kind = SEQ_SINGLE;

        case (dec.opcode)
            OP_HLT:        dec.seq_kind = SEQ_STOP;
            OP_LD, OP_OTM: dec.seq_kind = SEQ_MEM_EXEC;  // Memory data lands a cycle later

            // Direct branches
            OP_BDQ: dec.cond = COND_ZERO;
            OP_BDE: dec.cond = COND_NOT_ZERO;
            OP_BDT: dec.cond = COND_LESS;
            OP_BDS: dec.cond = COND_CARRY;

            // Indexed branches with the same tests
            OP_BXQ, OP_BXE, OP_BXT, OP_BXS: begin
                dec.bra_src = BRA_INDEXED;
                case (dec.opcode)
                    OP_BXQ:  dec.cond = COND_ZERO;
                    OP_BXE:  dec.cond = COND_NOT_ZERO;
                    OP_BXT:  dec.cond = COND_LESS;
                    default: dec.cond = COND_CARRY;
                endcase
            end

            // ALU group
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_NOT, OP_SHL, OP_SHR: begin
                case (dec.opcode)
                    OP_ADD:  dec.alu_op = ALU_ADD;
                    OP_SUB:  dec.alu_op = ALU_SUB;  // CMP when ignore_dest set
                    OP_AND:  dec.alu_op = ALU_AND;
                    OP_OR:   dec.alu_op = ALU_OR;
                    OP_XOR:  dec.alu_op = ALU_XOR;
                    OP_NOT:  dec.alu_op = ALU_NOT;
                    OP_SHL:  dec.alu_op = ALU_SHL;
                    default: dec.alu_op = ALU_SHR;
                endcase
                // Compare style ops update flags only and skip write-back
                dec.seq_kind = ignore_dest ? SEQ_SINGLE : SEQ_ALU_WB;
            end

            default: ;  // NOP and unused codes
        endcase
    end

endmodule

// File: src/seq_pkg.sv
package seq_pkg;

    // ------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------
    localparam int DATA_W = 16;  // Instruction word
    localparam int OPC_W  = 5;
    localparam int REG_AW = 3;   // Register file address
    localparam int FLAG_W = 4;   // V N C Z

    // Instruction field positions
    localparam int OPC_MSB      = 15;
    localparam int OPC_LSB      = 11;
    localparam int DEST_MSB     = 11;  // Shares bit 11 with the opcode
    localparam int DEST_LSB     = 9;
    localparam int SRC2_MSB     = 6;
    localparam int SRC2_LSB     = 4;
    localparam int SRC1_MSB     = 2;
    localparam int SRC1_LSB     = 0;
    localparam int IGN_DEST_BIT = 10;  // Set for compare style ALU ops

    // ------------------------------------------------------------
    // Encodings
    // ------------------------------------------------------------
    typedef enum logic [OPC_W-1:0] {
        OP_NOP = 5'd0,  OP_HLT = 5'd1,  OP_JMP = 5'd2,  OP_JPL = 5'd3,
        OP_RET = 5'd4,  OP_OTR = 5'd5,  OP_OTM = 5'd6,  OP_LDI = 5'd7,
        OP_LD  = 5'd8,  OP_ST  = 5'd9,  OP_STX = 5'd10, OP_MOV = 5'd11,
        OP_BDQ = 5'd12, OP_BDE = 5'd13, OP_BDT = 5'd14, OP_BDS = 5'd15,
        OP_BXQ = 5'd16, OP_BXE = 5'd17, OP_BXT = 5'd18, OP_BXS = 5'd19,
        OP_ADD = 5'd20, OP_SUB = 5'd21, OP_AND = 5'd22, OP_OR  = 5'd23,
        OP_XOR = 5'd24, OP_NOT = 5'd25, OP_SHL = 5'd26, OP_SHR = 5'd27
    } opcode_e;  // 28..31 behave as NOP

    typedef enum logic [3:0] {
        S_RESET, S_READY, S_FETCH_ADDR, S_FETCH_IR,
        S_DECODE, S_EXECUTE, S_ALU_WB, S_HALT
    } state_e;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0, ALU_SUB = 4'd1, ALU_AND = 4'd2, ALU_OR   = 4'd3,
        ALU_XOR = 4'd4, ALU_NOT = 4'd5, ALU_SHL = 4'd6, ALU_SHR  = 4'd7,
        ALU_NONE = 4'd9
    } alu_op_e;

    typedef enum logic [2:0] {
        COND_NEVER, COND_ZERO, COND_NOT_ZERO, COND_LESS, COND_CARRY
    } cond_e;

    typedef enum logic [1:0] {SEQ_SINGLE, SEQ_MEM_EXEC, SEQ_ALU_WB, SEQ_STOP} seq_kind_e;

    typedef enum logic [1:0] {PC_BRANCH = 2'd0, PC_RETURN = 2'd1, PC_SRC1 = 2'd2} pc_src_e;

    typedef enum logic [1:0] {
        ADDR_PC = 2'd0, ADDR_SRC2 = 2'd1, ADDR_IMM_LO = 2'd2, ADDR_IMM_HI = 2'd3
    } addr_src_e;

    typedef enum logic [1:0] {
        DATA_ZEXT = 2'd0, DATA_MEM = 2'd1, DATA_ALU = 2'd2, DATA_SRC1 = 2'd3
    } data_src_e;

    typedef enum logic {OUT_MEM, OUT_REGFILE} out_sel_e;
    typedef enum logic {BRA_INDEXED = 1'b0, BRA_DIRECT = 1'b1} bra_src_e;

    // ------------------------------------------------------------
    // Bundles
    // ------------------------------------------------------------
    typedef struct packed {
        logic v;  // Overflow
        logic n;  // Sign
        logic c;  // Carry out
        logic z;  // Zero result in bit 0
    } alu_flags_t;

    typedef struct packed {
        logic [REG_AW-1:0] dest;
        logic [REG_AW-1:0] src2;
        logic [REG_AW-1:0] src1;
    } reg_fields_t;

    typedef struct packed {
        opcode_e   opcode;
        alu_op_e   alu_op;    // ALU_NONE for non-ALU opcodes
        cond_e     cond;      // COND_NEVER unless a branch
        bra_src_e  bra_src;
        seq_kind_e seq_kind;  // Length of the instruction tail
    } decoded_t;

    typedef struct packed {
        logic      stk_ld;
        bra_src_e  bra_src;
        logic      ir_ld;
        logic      pc_rst;
        logic      pc_inc;
        logic      pc_ld;
        pc_src_e   pc_src;
        logic      mem_en;
        logic      mem_wr;   // High writes, low reads
        addr_src_e addr_src;
        logic      reg_we;
        data_src_e data_src;
        alu_op_e   alu_op;
        logic      alu_ld;
        logic      flg_ld;
        logic      flg_rst;
        logic      out_ld;
        out_sel_e  out_sel;
    } ctrl_t;

    // Nothing enabled and muxes at their resting selects
    localparam ctrl_t CTRL_IDLE = '{
        stk_ld: 1'b0, bra_src: BRA_DIRECT, ir_ld: 1'b0, pc_rst: 1'b0,
        pc_inc: 1'b0, pc_ld: 1'b0, pc_src: PC_BRANCH, mem_en: 1'b0,
        mem_wr: 1'b0, addr_src: ADDR_PC, reg_we: 1'b0, data_src: DATA_ZEXT,
        alu_op: ALU_NONE, alu_ld: 1'b0, flg_ld: 1'b0, flg_rst: 1'b0,
        out_ld: 1'b0, out_sel: OUT_REGFILE
    };

endpackage
